// File: acq_pkg.sv
////////////////////////////////////////////////////////////
// types for the acquisition side
// sequencer state encoding and channel number
////////////////////////////////////////////////////////////

package acq_pkg;

	// one state per step of the b13 converter sequence
	// encodings follow the b13 GPxxx numbering
	typedef enum logic [2:0] {
		// first enable of the mux after reset
		ACQ_MUX_ON   = 3'b000,
		// mux settling time
		ACQ_SETTLE   = 3'b001,
		// raise start of conversion
		ACQ_START    = 3'b010,
		// sample held until the transfer is released
		ACQ_HOLD     = 3'b011,
		// spare cycle after sample_ready rises
		ACQ_NOTIFY_W = 3'b100,
		// converter busy, wait for eoc low
		ACQ_CONVERT  = 3'b101,
		// byte strobe done, advance channel
		ACQ_STROBE   = 3'b110,
		// flag the sample to the transfer side
		ACQ_NOTIFY   = 3'b111
	} acq_state_t;

	// channel number as driven on canale
	typedef logic [3:0] channel_t;

endpackage

// File: acq_sequencer.sv
////////////////////////////////////////////////////////////
// acquisition sequencer
// drives the adc handshake and the input mux enable
// steps canale through the channels and flags each sample
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "b13_macros.svh"

module acq_sequencer (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              eoc,
	input  logic              xfer_done,
	output logic              soc,
	output logic              load_dato,
	output logic              mux_en,
	output logic              sample_ready,
	output acq_pkg::channel_t canale
);

	acq_pkg::acq_state_t state;
	acq_pkg::channel_t   next_canale;

	// channel counter wraps modulo the channel count
	always_comb begin
		if (canale == acq_pkg::channel_t'(`ACQ_CHANNELS - 1)) begin
			next_canale = '0;
		end else begin
			next_canale = canale + acq_pkg::channel_t'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state        <= acq_pkg::ACQ_MUX_ON;
			soc          <= 1'b0;
			load_dato    <= 1'b0;
			mux_en       <= 1'b0;
			sample_ready <= 1'b0;
			canale       <= '0;
		end else begin
			case (state)
				acq_pkg::ACQ_MUX_ON: begin
					mux_en <= 1'b1;
					state  <= acq_pkg::ACQ_SETTLE;
				end
				// one idle cycle lets the mux output settle
				acq_pkg::ACQ_SETTLE: begin
					state <= acq_pkg::ACQ_START;
				end
				acq_pkg::ACQ_START: begin
					soc   <= 1'b1;
					state <= acq_pkg::ACQ_CONVERT;
				end
				// eoc high means the converter is still busy
				acq_pkg::ACQ_CONVERT: begin
					if (!eoc) begin
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						state     <= acq_pkg::ACQ_STROBE;
					end
				end
				acq_pkg::ACQ_STROBE: begin
					load_dato <= 1'b0;
					soc       <= 1'b0;
					canale    <= next_canale;
					state     <= acq_pkg::ACQ_NOTIFY;
				end
				acq_pkg::ACQ_NOTIFY: begin
					sample_ready <= 1'b1;
					state        <= acq_pkg::ACQ_NOTIFY_W;
				end
				acq_pkg::ACQ_NOTIFY_W: begin
					state <= acq_pkg::ACQ_HOLD;
				end
				// hold the sample until both frames are out
				// mux is enabled right away for the next conversion
				acq_pkg::ACQ_HOLD: begin
					if (xfer_done) begin
						sample_ready <= 1'b0;
						mux_en       <= 1'b1;
						state        <= acq_pkg::ACQ_SETTLE;
					end
				end
			endcase
		end
	end

	// byte strobe falls inside the conversion window and soc drops after it
	a_strobe_in_conv: assert property (@(posedge clock) disable iff (!rst_n)
		load_dato |-> soc ##1 (!soc && !load_dato));

	// channel only moves right after a strobe and never leaves the range
	a_channel_step: assert property (@(posedge clock) disable iff (!rst_n)
		$changed(canale) |-> $past(load_dato) && (canale < `ACQ_CHANNELS));

endmodule

// File: b13_macros.svh
////////////////////////////////////////////////////////////
// global constants of the sensor link
// bit timing of the serial line and multiplexer channel count
////////////////////////////////////////////////////////////

`ifndef B13_MACROS_SVH
`define B13_MACROS_SVH

// clock cycles each line bit is held
// also used as the lead gap between an accepted send and the start bit
`define TX_BIT_CYCLES 106

// number of analog multiplexer channels
// channel counter wraps back to 0 after the last one
`define ACQ_CHANNELS 8

`endif

// File: frame_transmitter.sv
////////////////////////////////////////////////////////////
// serial frame transmitter
// byte buffer with full flag, dsr check and error flag
// bit serializer for start, msb first data and stop
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "b13_macros.svh"

module frame_transmitter (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 load,
	input  logic                 send,
	input  logic                 dsr,
	input  link_pkg::data_byte_t data_in,
	output logic                 data_out,
	output logic                 error,
	output logic                 frame_done
);

	localparam int CNT_W = $clog2(`TX_BIT_CYCLES);

	link_pkg::data_byte_t out_reg;
	link_pkg::data_byte_t shift_reg;
	link_pkg::frame_bit_t next_bit;
	link_pkg::frame_bit_t bit_after;
	logic [CNT_W-1:0]     tx_cnt;
	logic                 buf_full;
	logic                 send_en;
	logic                 last_bit;
	logic                 tick;
	logic                 accept;
	logic                 line_bit;
	logic                 is_data;

	// a send needs a full buffer and the receiver ready
	assign accept = send && buf_full && dsr;
	// end of one bit period
	assign tick   = send_en && (tx_cnt == CNT_W'(`TX_BIT_CYCLES - 1));

	// line level and successor of the next bit to go out
	always_comb begin
		line_bit  = 1'b1;
		bit_after = link_pkg::FB_START;
		is_data   = 1'b0;
		case (next_bit)
			link_pkg::FB_START: begin
				line_bit  = 1'b0;
				bit_after = link_pkg::FB_BIT0;
			end
			link_pkg::FB_BIT0, link_pkg::FB_BIT1, link_pkg::FB_BIT2,
			link_pkg::FB_BIT3, link_pkg::FB_BIT4, link_pkg::FB_BIT5,
			link_pkg::FB_BIT6: begin
				line_bit  = shift_reg[7];
				is_data   = 1'b1;
				bit_after = link_pkg::frame_bit_t'(next_bit + 4'd1);
			end
			link_pkg::FB_BIT7: begin
				line_bit  = shift_reg[7];
				is_data   = 1'b1;
				bit_after = link_pkg::FB_STOP;
			end
			default: begin
				line_bit  = 1'b1;
				bit_after = link_pkg::FB_START;
			end
		endcase
	end

	// buffer state and error flag
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			buf_full <= 1'b0;
			error    <= 1'b0;
		end else begin
			if (load) begin
				// a load into a full buffer is lost
				error    <= buf_full;
				buf_full <= 1'b1;
			end else if (send) begin
				error <= !accept;
			end
			// buffer frees when the frame ends, sent or refused
			if ((send && !accept) || (tick && last_bit)) begin
				buf_full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load && !buf_full) begin
			out_reg <= data_in;
		end
		// msb goes first so shift left after each data bit
		if (accept) begin
			shift_reg <= out_reg;
		end else if (tick && !last_bit && is_data) begin
			shift_reg <= {shift_reg[6:0], 1'b0};
		end
	end

	// bit timing and line driver
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			send_en    <= 1'b0;
			last_bit   <= 1'b0;
			tx_cnt     <= '0;
			next_bit   <= link_pkg::FB_START;
			data_out   <= 1'b1;
			frame_done <= 1'b0;
		end else begin
			// a refused send ends its frame at once
			frame_done <= send && !accept;
			if (accept) begin
				send_en  <= 1'b1;
				last_bit <= 1'b0;
				tx_cnt   <= '0;
				next_bit <= link_pkg::FB_START;
			end else if (tick) begin
				tx_cnt <= '0;
				if (last_bit) begin
					// stop bit has been held a full period
					send_en    <= 1'b0;
					last_bit   <= 1'b0;
					frame_done <= 1'b1;
				end else begin
					data_out <= line_bit;
					next_bit <= bit_after;
					last_bit <= (next_bit == link_pkg::FB_STOP);
				end
			end else if (send_en) begin
				tx_cnt <= tx_cnt + 1'b1;
			end
		end
	end

	a_no_error_in_frame: assert property (@(posedge clock) disable iff (!rst_n)
		!(error && send_en));

	// frame_done follows either a refused send or the end of the stop bit
	a_frame_done_cause: assert property (@(posedge clock) disable iff (!rst_n)
		frame_done |-> ($past(send) && error) || ($past(last_bit) && !send_en));

endmodule

// File: link_pkg.sv
////////////////////////////////////////////////////////////
// types for the transfer and serial side
// controller states, frame bit position and data byte
////////////////////////////////////////////////////////////

package link_pkg;

	// two frames per sample then release of the sequencer
	typedef enum logic [2:0] {
		X_IDLE    = 3'b000,
		X_LOAD1   = 3'b001,
		X_SEND1   = 3'b010,
		X_WAIT1   = 3'b011,
		X_LOAD2   = 3'b100,
		X_SEND2   = 3'b101,
		X_WAIT2   = 3'b110,
		X_RELEASE = 3'b111
	} xfer_state_t;

	// next bit to put on the line
	// data bits are contiguous so the serializer can step them by one
	typedef enum logic [3:0] {
		FB_START = 4'b0001,
		FB_STOP  = 4'b0010,
		FB_BIT0  = 4'b0011,
		FB_BIT1  = 4'b0100,
		FB_BIT2  = 4'b0101,
		FB_BIT3  = 4'b0110,
		FB_BIT4  = 4'b0111,
		FB_BIT5  = 4'b1000,
		FB_BIT6  = 4'b1001,
		FB_BIT7  = 4'b1010
	} frame_bit_t;

	// one converted byte
	typedef logic [7:0] data_byte_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build the sensor link testbench with Verilator and run it
# exit status is nonzero when the simulation fails
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_sensor_link -o sim_sensor_link \
	&& ./obj_dir/sim_sensor_link \
	|| { echo "sensor link simulation failed"; exit 1; }

// File: sensor_link_top.sv
////////////////////////////////////////////////////////////
// sensor link top level
// acquisition sequencer, transfer controller, frame transmitter
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module sensor_link_top (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 eoc,
	input  logic                 dsr,
	input  link_pkg::data_byte_t data_in,
	output logic                 soc,
	output logic                 load_dato,
	output logic                 mux_en,
	output logic                 add_mpx2,
	output logic                 error,
	output logic                 data_out,
	output acq_pkg::channel_t    canale
);

	// sequencer to controller handshake
	logic sample_ready;
	logic xfer_done;
	// controller to transmitter strobes
	logic load;
	logic send;
	logic frame_done;

	acq_sequencer i_acq_sequencer (
		.clock        (clock),
		.rst_n        (rst_n),
		.eoc          (eoc),
		.xfer_done    (xfer_done),
		.soc          (soc),
		.load_dato    (load_dato),
		.mux_en       (mux_en),
		.sample_ready (sample_ready),
		.canale       (canale)
	);

	transfer_controller i_transfer_controller (
		.clock        (clock),
		.rst_n        (rst_n),
		.sample_ready (sample_ready),
		.frame_done   (frame_done),
		.load         (load),
		.send         (send),
		.add_mpx2     (add_mpx2),
		.xfer_done    (xfer_done)
	);

	frame_transmitter i_frame_transmitter (
		.clock      (clock),
		.rst_n      (rst_n),
		.load       (load),
		.send       (send),
		.dsr        (dsr),
		.data_in    (data_in),
		.data_out   (data_out),
		.error      (error),
		.frame_done (frame_done)
	);

endmodule

// File: sensor_link_trace.txt
// dsr  byte_mpx1  byte_mpx2  channel_after_sample
// hex columns, one sample per line
1 A5 5A 1
1 3C C3 2
1 FF 00 3
0 81 7E 4
1 01 80 5
1 96 69 6
0 F0 0F 7
0 55 AA 0
1 12 34 1
1 E7 18 2
1 00 FF 3
1 C8 4B 4

// File: tb_sensor_link.sv
////////////////////////////////////////////////////////////
// testbench for the sensor link
// trace-driven samples, adc model with random busy time
// serial line decoder and compare tasks
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "b13_macros.svh"

module tb_sensor_link;

	localparam int NUM_SAMPLES = 12;
	localparam int TRACE_COLS  = 4;
	localparam int BIT_CYCLES  = `TX_BIT_CYCLES;
	// two full frames plus acquisition overhead for every sample
	localparam int CYCLE_LIMIT = NUM_SAMPLES * (2 * 11 * BIT_CYCLES + 64);

	logic                 clock;
	logic                 rst_n;
	logic                 eoc = 1'b0;
	logic                 dsr;
	link_pkg::data_byte_t data_in = '0;
	logic                 soc;
	logic                 load_dato;
	logic                 mux_en;
	logic                 add_mpx2;
	logic                 error;
	logic                 data_out;
	acq_pkg::channel_t    canale;

	// dsr, byte_lo, byte_hi and channel for every sample
	logic [7:0]           trace_mem [0:NUM_SAMPLES*TRACE_COLS-1];
	link_pkg::data_byte_t byte_lo = '0;
	link_pkg::data_byte_t byte_hi = '0;
	int                   cycle_count = 0;
	int                   busy_left = 0;
	logic                 conv_seen = 1'b0;

	sensor_link_top i_sensor_link_top (
		.clock     (clock),
		.rst_n     (rst_n),
		.eoc       (eoc),
		.dsr       (dsr),
		.data_in   (data_in),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.add_mpx2  (add_mpx2),
		.error     (error),
		.data_out  (data_out),
		.canale    (canale)
	);

	always #50 clock = ~clock;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input link_pkg::data_byte_t actual,
		input link_pkg::data_byte_t expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %0t: %s is %02h, expected %02h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_channel(input acq_pkg::channel_t actual,
		input acq_pkg::channel_t expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b",
				$time, what, actual, expected));
		end
	endtask

	// hard stop if the link stalls
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			abort_run($sformatf("timeout after %0d cycles, the link stopped making progress",
				cycle_count));
		end
	end

	// adc model
	// eoc stays busy for 1 to 20 cycles after soc
	// data_in follows add_mpx2
	always @(negedge clock) begin
		data_in = add_mpx2 ? byte_hi : byte_lo;
		// the byte strobe may only follow a finished conversion
		if (load_dato) begin
			check_flag(eoc, 1'b0, "eoc at load_dato");
		end
		if (!rst_n) begin
			eoc       = 1'b0;
			busy_left = 0;
			conv_seen = 1'b0;
		end else if (soc && !conv_seen) begin
			conv_seen = 1'b1;
			busy_left = 1 + int'($urandom % 20);
			eoc       = 1'b1;
		end else if (eoc) begin
			check_flag(soc, 1'b1, "soc while converter busy");
			busy_left = busy_left - 1;
			if (busy_left == 0) begin
				eoc = 1'b0;
			end
		end else if (!soc) begin
			conv_seen = 1'b0;
		end
	end

	// line decoder waits for a start edge then samples mid-bit
	// every edge inside the frame must sit on a bit boundary
	task automatic receive_frame(input logic mpx2_expected,
		output link_pkg::data_byte_t rx);
		int   offset;
		logic prev;
		rx = '0;
		do begin
			@(negedge clock);
		end while (data_out !== 1'b0);
		prev = 1'b0;
		for (offset = 1; offset < 10 * BIT_CYCLES; offset++) begin
			@(negedge clock);
			if (data_out !== prev) begin
				check_flag(offset % BIT_CYCLES == 0, 1'b1, "line edge on bit boundary");
				prev = data_out;
			end
			if (offset % BIT_CYCLES == BIT_CYCLES / 2) begin
				case (offset / BIT_CYCLES)
					0: begin
						check_flag(data_out, 1'b0, "start bit");
						check_flag(add_mpx2, mpx2_expected, "add_mpx2 during frame");
						check_flag(error, 1'b0, "error during frame");
					end
					9: check_flag(data_out, 1'b1, "stop bit");
					// data arrives msb first
					default: rx = {rx[6:0], data_out};
				endcase
			end
		end
	endtask

	initial begin
		int                   sample;
		int                   base;
		logic                 sample_dsr;
		acq_pkg::channel_t    chan_expected;
		link_pkg::data_byte_t rx;
		void'($urandom(32'h7846));
		clock = 1'b0;
		rst_n = 1'b0;
		dsr   = 1'b0;
		$readmemh("sensor_link_trace.txt", trace_mem);
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_flag(soc, 1'b0, "soc in reset");
		check_flag(load_dato, 1'b0, "load_dato in reset");
		check_flag(mux_en, 1'b0, "mux_en in reset");
		check_flag(add_mpx2, 1'b0, "add_mpx2 in reset");
		check_flag(error, 1'b0, "error in reset");
		check_flag(data_out, 1'b1, "data_out in reset");
		check_channel(canale, acq_pkg::channel_t'(0), "canale in reset");
		rst_n = 1'b1;
		// mux comes up before the first conversion
		while (mux_en !== 1'b1) begin
			@(negedge clock);
			check_flag(soc, 1'b0, "soc before mux_en");
		end
		for (sample = 0; sample < NUM_SAMPLES; sample++) begin
			base          = sample * TRACE_COLS;
			sample_dsr    = trace_mem[base][0];
			byte_lo       = trace_mem[base + 1];
			byte_hi       = trace_mem[base + 2];
			chan_expected = acq_pkg::channel_t'(trace_mem[base + 3]);
			dsr           = sample_dsr;
			// byte strobe ends the conversion and drops the mux enable
			while (load_dato !== 1'b1) begin
				@(negedge clock);
			end
			check_flag(soc, 1'b1, "soc at load_dato");
			check_flag(mux_en, 1'b0, "mux_en at load_dato");
			@(negedge clock);
			check_flag(load_dato, 1'b0, "load_dato after one cycle");
			check_flag(soc, 1'b0, "soc after strobe");
			check_channel(canale, chan_expected, "canale after sample");
			if (sample_dsr) begin
				receive_frame(1'b0, rx);
				check_byte(rx, byte_lo, "first frame byte");
				receive_frame(1'b1, rx);
				check_byte(rx, byte_hi, "second frame byte");
			end else begin
				// both sends are refused and the line idles until the next mux enable
				while (mux_en !== 1'b1) begin
					@(negedge clock);
					check_flag(data_out, 1'b1, "line with dsr low");
				end
				check_flag(error, 1'b1, "error after refused send");
			end
		end
		$display("No errors");
		$finish;
	end

endmodule

// File: transfer_controller.sv
////////////////////////////////////////////////////////////
// transfer controller
// two frames per sample with add_mpx2 selecting the byte
// load and send strobes and release of the sequencer
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module transfer_controller (
	input  logic clock,
	input  logic rst_n,
	input  logic sample_ready,
	input  logic frame_done,
	output logic load,
	output logic send,
	output logic add_mpx2,
	output logic xfer_done
);

	link_pkg::xfer_state_t state;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= link_pkg::X_IDLE;
			add_mpx2 <= 1'b0;
		end else begin
			case (state)
				link_pkg::X_IDLE: begin
					if (sample_ready) begin
						state <= link_pkg::X_LOAD1;
					end
				end
				link_pkg::X_LOAD1: begin
					state <= link_pkg::X_SEND1;
				end
				link_pkg::X_SEND1: begin
					state <= link_pkg::X_WAIT1;
				end
				// switch to the second mux byte once frame one is over
				link_pkg::X_WAIT1: begin
					if (frame_done) begin
						add_mpx2 <= 1'b1;
						state    <= link_pkg::X_LOAD2;
					end
				end
				link_pkg::X_LOAD2: begin
					state <= link_pkg::X_SEND2;
				end
				link_pkg::X_SEND2: begin
					state <= link_pkg::X_WAIT2;
				end
				link_pkg::X_WAIT2: begin
					if (frame_done) begin
						add_mpx2 <= 1'b0;
						state    <= link_pkg::X_RELEASE;
					end
				end
				// sequencer clears sample_ready on this pulse
				link_pkg::X_RELEASE: begin
					state <= link_pkg::X_IDLE;
				end
			endcase
		end
	end

	// strobes decoded from the state
	assign load = (state == link_pkg::X_LOAD1) || (state == link_pkg::X_LOAD2);
	assign send = (state == link_pkg::X_SEND1) || (state == link_pkg::X_SEND2);
	assign xfer_done = (state == link_pkg::X_RELEASE);

	// send always comes right behind its load
	a_load_then_send: assert property (@(posedge clock) disable iff (!rst_n)
		load |-> !send ##1 (send && !load));

	// release only a sample the sequencer is still holding
	a_release_held: assert property (@(posedge clock) disable iff (!rst_n)
		xfer_done |-> sample_ready);

endmodule

// File: vlog.f
+incdir+.
acq_pkg.sv
link_pkg.sv
acq_sequencer.sv
frame_transmitter.sv
transfer_controller.sv
sensor_link_top.sv
tb_sensor_link.sv
